/* design/tiler_pkg.sv */
`default_nettype none

package tiler_pkg;

  // Systolic array shape
  localparam int ARRAY_WIDTH  = 12;
  localparam int ARRAY_HEIGHT = 4;
  localparam int PIPE_REGS    = 3;
  // Columns consumed per tile, one per FMA pipeline slot
  localparam int COL_TILE     = ARRAY_HEIGHT * (PIPE_REGS + 1);

  localparam int REG_AW = 4;

  typedef logic [31:0]       word_t;
  typedef logic [15:0]       dim_t;
  typedef logic [7:0]        lftovr_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  // Config registers
  localparam reg_addr_t ADDR_MCFG0     = reg_addr_t'(0);
  localparam reg_addr_t ADDR_MCFG1     = reg_addr_t'(1);
  localparam reg_addr_t ADDR_MACFG     = reg_addr_t'(2);
  localparam reg_addr_t ADDR_TRIGGER   = reg_addr_t'(3);
  localparam reg_addr_t ADDR_STATUS    = reg_addr_t'(4);

  // Result registers
  localparam reg_addr_t ADDR_X_ITERS    = reg_addr_t'(5);
  localparam reg_addr_t ADDR_W_ITERS    = reg_addr_t'(6);
  localparam reg_addr_t ADDR_LEFTOVERS  = reg_addr_t'(7);
  localparam reg_addr_t ADDR_TOT_STORES = reg_addr_t'(8);
  localparam reg_addr_t ADDR_W_TOT_LEN  = reg_addr_t'(9);
  localparam reg_addr_t ADDR_TOT_X_READ = reg_addr_t'(10);
  localparam reg_addr_t ADDR_X_SLOTS    = reg_addr_t'(11);
  localparam reg_addr_t ADDR_OP_SEL     = reg_addr_t'(12);

  typedef enum logic [2:0] {
    MATMUL,
    GEMM,
    ADDMAX,
    ADDMIN,
    MULMAX,
    MULMIN,
    MAXMIN
  } gemm_op_e;

  typedef enum logic [2:0] {
    FLOAT16,
    FLOAT8,
    FLOAT16ALT,
    FLOAT8ALT
  } gemm_fmt_e;

  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1
  } rnd_mode_e;

  // Codes follow the FPU operation numbering
  typedef enum logic [4:0] {
    FPU_FMADD  = 5'd0,
    FPU_ADD    = 5'd2,
    FPU_MUL    = 5'd3,
    FPU_MINMAX = 5'd7
  } fpu_op_e;

  typedef enum logic [1:0] {
    IDLE,
    MUL1,
    MUL2,
    DONE
  } tiler_state_e;

endpackage

`default_nettype wire

/* design/seq_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_mult #(
  parameter int A_W = 16,
  parameter int B_W = 16
) (
  input  logic             clk_int,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             start_i,
  input  logic [A_W-1:0]   a_i,
  input  logic [B_W-1:0]   b_i,
  output logic             done_o,
  output logic [A_W+B_W-1:0] prod_o
);

  localparam int CNT_W = $clog2(A_W) + 1;
  localparam int P_W   = A_W + B_W;

  logic [CNT_W-1:0] cnt;
  logic             running;
  logic [A_W-1:0]   a_q;
  logic [P_W-1:0]   b_q;
  logic [P_W-1:0]   b_ext;
  logic [P_W-1:0]   acc;

  assign b_ext  = {{A_W{1'b0}}, b_i};
  assign prod_o = acc;

  // Bit 0 is handled on the start edge, so the last bit lands A_W-1 cycles later
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      running <= 1'b0;
      cnt     <= '0;
      done_o  <= 1'b0;
    end else if (clear_i) begin
      running <= 1'b0;
      cnt     <= '0;
      done_o  <= 1'b0;
    end else if (start_i) begin
      running <= 1'b1;
      cnt     <= CNT_W'(1);
      done_o  <= 1'b0;
    end else if (running) begin
      cnt <= cnt + 1'b1;
      if (cnt == CNT_W'(A_W - 1)) begin
        running <= 1'b0;
        done_o  <= 1'b1;
      end
    end else begin
      done_o <= 1'b0;
    end
  end

  // Shift-add datapath
  always_ff @(posedge clk_int) begin
    if (start_i) begin
      a_q <= a_i >> 1;
      b_q <= b_ext << 1;
      acc <= a_i[0] ? b_ext : '0;
    end else if (running) begin
      a_q <= a_q >> 1;
      b_q <= b_q << 1;
      if (a_q[0]) acc <= acc + b_q;
    end
  end

  assert property (@(posedge clk_int) disable iff (!rst_ni)
    done_o |-> $past(start_i, A_W));

endmodule

`default_nettype wire

/* design/tiler_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module tiler_regfile
  import tiler_pkg::*;
(
  input  logic      clk_int,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      wr_en_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i,
  input  reg_addr_t rd_addr_i,
  output word_t     rd_data_o,
  output logic      start_o,
  output dim_t      m_size_o,
  output dim_t      n_size_o,
  output dim_t      k_size_o,
  output gemm_op_e  gemm_op_o,
  output gemm_fmt_e gemm_fmt_o,
  input  logic      busy_i,
  input  logic      done_i,
  input  word_t     x_iters_i,
  input  word_t     w_iters_i,
  input  word_t     leftovers_i,
  input  word_t     tot_stores_i,
  input  word_t     w_tot_len_i,
  input  word_t     tot_x_read_i,
  input  word_t     x_slots_i,
  input  word_t     op_sel_i
);

  word_t mcfg0_q;
  word_t mcfg1_q;
  word_t macfg_q;
  logic  valid_q;
  logic  trigger;

  assign trigger = wr_en_i && (wr_addr_i == ADDR_TRIGGER);

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      mcfg0_q <= '0;
      mcfg1_q <= '0;
      macfg_q <= '0;
    end else if (wr_en_i) begin
      case (wr_addr_i)
        ADDR_MCFG0: mcfg0_q <= wr_data_i;
        ADDR_MCFG1: mcfg1_q <= wr_data_i;
        ADDR_MACFG: macfg_q <= wr_data_i;
        default: ;
      endcase
    end
  end

  // Trigger becomes a start pulse unless a job is in flight
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      start_o <= 1'b0;
      valid_q <= 1'b0;
    end else if (clear_i) begin
      start_o <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      start_o <= trigger && !busy_i;
      if (start_o) valid_q <= 1'b0;
      else if (done_i) valid_q <= 1'b1;
    end
  end

  assign m_size_o   = mcfg0_q[15:0];
  assign k_size_o   = mcfg0_q[31:16];
  assign n_size_o   = mcfg1_q[15:0];
  assign gemm_op_o  = gemm_op_e'(macfg_q[12:10]);
  assign gemm_fmt_o = gemm_fmt_e'(macfg_q[9:7]);

  always_comb begin
    case (rd_addr_i)
      ADDR_MCFG0:      rd_data_o = mcfg0_q;
      ADDR_MCFG1:      rd_data_o = mcfg1_q;
      ADDR_MACFG:      rd_data_o = macfg_q;
      ADDR_STATUS:     rd_data_o = {30'd0, valid_q, busy_i};
      ADDR_X_ITERS:    rd_data_o = x_iters_i;
      ADDR_W_ITERS:    rd_data_o = w_iters_i;
      ADDR_LEFTOVERS:  rd_data_o = leftovers_i;
      ADDR_TOT_STORES: rd_data_o = tot_stores_i;
      ADDR_W_TOT_LEN:  rd_data_o = w_tot_len_i;
      ADDR_TOT_X_READ: rd_data_o = tot_x_read_i;
      ADDR_X_SLOTS:    rd_data_o = x_slots_i;
      ADDR_OP_SEL:     rd_data_o = op_sel_i;
      default:         rd_data_o = '0;
    endcase
  end

  assert property (@(posedge clk_int) disable iff (!rst_ni) start_o |=> !start_o);

endmodule

`default_nettype wire

/* design/gemm_tiler.sv */
`timescale 1ns/1ps
`default_nettype none

module gemm_tiler
  import tiler_pkg::*;
(
  input  logic      clk_int,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      start_i,
  input  dim_t      m_size_i,
  input  dim_t      n_size_i,
  input  dim_t      k_size_i,
  input  gemm_op_e  gemm_op_i,
  input  gemm_fmt_e gemm_fmt_i,
  output logic      busy_o,
  output logic      done_o,
  output word_t     x_iters_o,
  output word_t     w_iters_o,
  output word_t     leftovers_o,
  output word_t     tot_stores_o,
  output word_t     w_tot_len_o,
  output word_t     tot_x_read_o,
  output word_t     x_slots_o,
  output word_t     op_sel_o
);

  tiler_state_e state_q;
  dim_t         m_q, n_q, k_q, m_sel, n_sel, k_sel;
  gemm_op_e     op_q, op_sel;
  gemm_fmt_e    fmt_q, fmt_sel;
  dim_t         x_rows_iter, x_cols_iter, w_rows_iter, w_cols_iter;
  lftovr_t      x_rows_lft, x_cols_lft, w_rows_lft, w_cols_lft, slots_lft;
  word_t        x_slots;
  logic [31:0]  stores_prod;
  logic [47:0]  wlen_prod, xread_prod;
  logic         stores_done, wlen_done, xread_done, res_latch;
  rnd_mode_e    stage1_rnd, stage2_rnd;
  fpu_op_e      stage1_op;
  word_t        op_word;

  // Sizes are sampled on start and held for the whole job
  always_ff @(posedge clk_int) begin
    if (start_i) begin
      m_q   <= m_size_i;
      n_q   <= n_size_i;
      k_q   <= k_size_i;
      op_q  <= gemm_op_i;
      fmt_q <= gemm_fmt_i;
    end
  end

  assign m_sel   = start_i ? m_size_i : m_q;
  assign n_sel   = start_i ? n_size_i : n_q;
  assign k_sel   = start_i ? k_size_i : k_q;
  assign op_sel  = start_i ? gemm_op_i : op_q;
  assign fmt_sel = start_i ? gemm_fmt_i : fmt_q;

  assign x_rows_lft = lftovr_t'(m_sel % ARRAY_WIDTH);
  assign x_cols_lft = lftovr_t'(n_sel % COL_TILE);
  assign w_rows_lft = lftovr_t'(n_sel % ARRAY_HEIGHT);
  assign w_cols_lft = lftovr_t'(k_sel % COL_TILE);
  assign slots_lft  = lftovr_t'(x_cols_lft % ARRAY_HEIGHT);

  // Ceiling divisions bump the quotient when a partial tile remains
  assign x_rows_iter = dim_t'(m_sel / ARRAY_WIDTH) + dim_t'(x_rows_lft != '0);
  assign x_cols_iter = dim_t'(n_sel / COL_TILE) + dim_t'(x_cols_lft != '0);
  assign w_cols_iter = dim_t'(k_sel / COL_TILE) + dim_t'(w_cols_lft != '0);
  assign w_rows_iter = (w_rows_lft != '0) ?
                       n_sel + dim_t'(ARRAY_HEIGHT) - dim_t'(w_rows_lft) : n_sel;
  assign x_slots     = (slots_lft != '0) ?
                       word_t'(x_cols_lft) + word_t'(ARRAY_HEIGHT) - word_t'(slots_lft) :
                       word_t'(x_cols_lft);

  seq_mult #(.A_W(16), .B_W(16)) u_stores_mult (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .start_i (start_i),
    .a_i     (x_rows_iter),
    .b_i     (w_cols_iter),
    .done_o  (stores_done),
    .prod_o  (stores_prod)
  );

  seq_mult #(.A_W(16), .B_W(32)) u_wlen_mult (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .start_i (stores_done),
    .a_i     (w_rows_iter),
    .b_i     (stores_prod),
    .done_o  (wlen_done),
    .prod_o  (wlen_prod)
  );

  seq_mult #(.A_W(16), .B_W(32)) u_xread_mult (
    .clk_int (clk_int),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .start_i (stores_done),
    .a_i     (x_cols_iter),
    .b_i     (stores_prod),
    .done_o  (xread_done),
    .prod_o  (xread_prod)
  );

  // Per-stage FPU settings
  always_comb begin
    stage1_rnd = (op_sel == MAXMIN) ? RTZ : RNE;
    case (op_sel)
      MATMUL, GEMM, ADDMIN, MULMIN, MAXMIN: stage2_rnd = RNE;
      default:                              stage2_rnd = RTZ;
    endcase
    case (op_sel)
      MATMUL, GEMM:   stage1_op = FPU_FMADD;
      ADDMAX, ADDMIN: stage1_op = FPU_ADD;
      MULMAX, MULMIN: stage1_op = FPU_MUL;
      default:        stage1_op = FPU_MINMAX;
    endcase
    op_word = {stage1_rnd, stage2_rnd, stage1_op, FPU_MINMAX, fmt_sel, fmt_sel,
               9'd0, op_sel != MATMUL};
  end

  assign res_latch = (state_q == MUL2) && wlen_done && xread_done;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else if (start_i) begin
      state_q <= MUL1;
    end else begin
      case (state_q)
        MUL1: if (stores_done) state_q <= MUL2;
        MUL2: if (res_latch) state_q <= DONE;
        DONE: state_q <= IDLE;
        default: ;
      endcase
    end
  end

  assign busy_o = start_i || (state_q != IDLE);
  assign done_o = (state_q == DONE);

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      x_iters_o    <= '0;
      w_iters_o    <= '0;
      leftovers_o  <= '0;
      tot_stores_o <= '0;
      w_tot_len_o  <= '0;
      tot_x_read_o <= '0;
      x_slots_o    <= '0;
      op_sel_o     <= '0;
    end else if (clear_i || res_latch) begin
      x_iters_o    <= clear_i ? '0 : {x_rows_iter, x_cols_iter};
      w_iters_o    <= clear_i ? '0 : {w_rows_iter, w_cols_iter};
      leftovers_o  <= clear_i ? '0 : {x_rows_lft, x_cols_lft, w_rows_lft, w_cols_lft};
      tot_stores_o <= clear_i ? '0 : stores_prod;
      w_tot_len_o  <= clear_i ? '0 : wlen_prod[31:0];
      tot_x_read_o <= clear_i ? '0 : xread_prod[31:0];
      x_slots_o    <= clear_i ? '0 : x_slots;
      op_sel_o     <= clear_i ? '0 : op_word;
    end
  end

  // Stage 2 spans the full 16-cycle multiply after MUL1
  assert property (@(posedge clk_int) disable iff (!rst_ni)
    done_o |-> $past(state_q) == MUL2 && $past(state_q, 17) == MUL1);

endmodule

`default_nettype wire

/* design/tiler_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tiler_top
  import tiler_pkg::*;
(
  input  logic      clk_int,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      wr_en_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i,
  input  reg_addr_t rd_addr_i,
  output word_t     rd_data_o,
  output logic      done_o,
  output logic      busy_o
);

  logic      start;
  dim_t      m_size, n_size, k_size;
  gemm_op_e  gemm_op;
  gemm_fmt_e gemm_fmt;
  word_t     x_iters, w_iters, leftovers, tot_stores;
  word_t     w_tot_len, tot_x_read, x_slots, op_sel;

  tiler_regfile u_regfile (
    .clk_int      (clk_int),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .wr_en_i      (wr_en_i),
    .wr_addr_i    (wr_addr_i),
    .wr_data_i    (wr_data_i),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o),
    .start_o      (start),
    .m_size_o     (m_size),
    .n_size_o     (n_size),
    .k_size_o     (k_size),
    .gemm_op_o    (gemm_op),
    .gemm_fmt_o   (gemm_fmt),
    .busy_i       (busy_o),
    .done_i       (done_o),
    .x_iters_i    (x_iters),
    .w_iters_i    (w_iters),
    .leftovers_i  (leftovers),
    .tot_stores_i (tot_stores),
    .w_tot_len_i  (w_tot_len),
    .tot_x_read_i (tot_x_read),
    .x_slots_i    (x_slots),
    .op_sel_i     (op_sel)
  );

  gemm_tiler u_tiler (
    .clk_int      (clk_int),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .start_i      (start),
    .m_size_i     (m_size),
    .n_size_i     (n_size),
    .k_size_i     (k_size),
    .gemm_op_i    (gemm_op),
    .gemm_fmt_i   (gemm_fmt),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .x_iters_o    (x_iters),
    .w_iters_o    (w_iters),
    .leftovers_o  (leftovers),
    .tot_stores_o (tot_stores),
    .w_tot_len_o  (w_tot_len),
    .tot_x_read_o (tot_x_read),
    .x_slots_o    (x_slots),
    .op_sel_o     (op_sel)
  );

endmodule

`default_nettype wire

/* sim/tb_tiler_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tiler_top
  import tiler_pkg::*;
();

  localparam int NUM_ROWS = 8;
  // Table rows plus about six job slots for the busy and clear scenarios
  localparam int CYCLE_LIMIT = (NUM_ROWS + 6) * 60;
  localparam int DONE_WAIT = 60;
  localparam int QUIET_WAIT = 40;

  typedef struct packed {
    dim_t       m;
    dim_t       n;
    dim_t       k;
    logic [2:0] op;
    logic [2:0] fmt;
    logic       rnd;
    word_t      stores;
  } row_t;

  logic      clk_int;
  logic      rst_ni;
  logic      clear_i;
  logic      wr_en_i;
  reg_addr_t wr_addr_i;
  word_t     wr_data_i;
  reg_addr_t rd_addr_i;
  word_t     rd_data_o;
  logic      done_o;
  logic      busy_o;

  row_t   rows [NUM_ROWS];
  word_t  exp_q [8];
  integer seed;
  int     cycle_cnt;
  int     err_cnt;
  int     row_errs;
  int     check_cnt;
  int     test_cnt;

  tiler_top dut_i (
    .clk_int   (clk_int),
    .rst_ni    (rst_ni),
    .clear_i   (clear_i),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_data_o),
    .done_o    (done_o),
    .busy_o    (busy_o)
  );

  always #4 clk_int = ~clk_int;

  always @(posedge clk_int) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // m, n, k, op, fmt, random sizes, expected tot_stores
  task automatic load_table();
    rows[0] = '{16'd24, 16'd32, 16'd48, 3'd0, 3'd0, 1'b0, 32'd6};
    rows[1] = '{16'd1, 16'd1, 16'd1, 3'd1, 3'd1, 1'b0, 32'd1};
    rows[2] = '{16'd13, 16'd17, 16'd19, 3'd2, 3'd2, 1'b0, 32'd4};
    rows[3] = '{16'd100, 16'd70, 16'd33, 3'd3, 3'd3, 1'b0, 32'd27};
    rows[4] = '{16'd0, 16'd0, 16'd0, 3'd4, 3'd0, 1'b1, 32'd0};
    rows[5] = '{16'd12, 16'd4, 16'd16, 3'd5, 3'd1, 1'b0, 32'd1};
    rows[6] = '{16'd0, 16'd0, 16'd0, 3'd6, 3'd2, 1'b1, 32'd0};
    // Code 7 is outside the op enum
    rows[7] = '{16'd35, 16'd46, 16'd61, 3'd7, 3'd3, 1'b0, 32'd12};
  endtask

  function automatic string result_name(input int idx);
    case (idx)
      0: return "x_iters";
      1: return "w_iters";
      2: return "leftovers";
      3: return "tot_stores";
      4: return "w_tot_len";
      5: return "tot_x_read";
      6: return "x_slots";
      default: return "op_sel";
    endcase
  endfunction

  task automatic flag_error();
    err_cnt++;
    row_errs++;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      flag_error();
    end
  endtask

  task automatic finish_test(input string label);
    test_cnt++;
    if (row_errs == 0) $display("%s: ok", label);
    else $display("%s: %0d errors", label, row_errs);
    row_errs = 0;
  endtask

  task automatic write_reg(input reg_addr_t addr, input word_t data);
    @(negedge clk_int);
    wr_en_i   = 1'b1;
    wr_addr_i = addr;
    wr_data_i = data;
    @(negedge clk_int);
    wr_en_i = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output word_t data);
    @(negedge clk_int);
    rd_addr_i = addr;
    #1;
    data = rd_data_o;
  endtask

  task automatic write_config(input dim_t m, input dim_t n, input dim_t k,
                              input logic [2:0] op, input logic [2:0] fmt);
    write_reg(ADDR_MCFG0, {k, m});
    write_reg(ADDR_MCFG1, {16'd0, n});
    write_reg(ADDR_MACFG, word_t'({op, fmt}) << 7);
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    while (!done_o && waited < DONE_WAIT) begin
      @(negedge clk_int);
      waited++;
    end
    assert (done_o) else begin
      $display("done_o did not pulse within %0d cycles", DONE_WAIT);
      flag_error();
    end
  endtask

  // Reference model of the tile rules and the op decode table
  task automatic model_job(input dim_t m, input dim_t n, input dim_t k,
                           input logic [2:0] op, input logic [2:0] fmt);
    int unsigned     x_rows;
    int unsigned     x_cols;
    int unsigned     w_rows;
    int unsigned     w_cols;
    int unsigned     slots;
    longint unsigned stores;
    logic [2:0]      rnd1;
    logic [2:0]      rnd2;
    logic [4:0]      fpu1;
    x_rows = (32'(m) + 11) / 12;
    x_cols = (32'(n) + 15) / 16;
    w_cols = (32'(k) + 15) / 16;
    w_rows = ((32'(n) + 3) / 4) * 4;
    slots  = (((32'(n) % 16) + 3) / 4) * 4;
    stores = 64'(x_rows) * 64'(w_cols);
    exp_q[0] = {x_rows[15:0], x_cols[15:0]};
    exp_q[1] = {w_rows[15:0], w_cols[15:0]};
    exp_q[2] = {8'(m % 12), 8'(n % 16), 8'(n % 4), 8'(k % 16)};
    exp_q[3] = stores[31:0];
    exp_q[4] = 32'(stores * 64'(w_rows[15:0]));
    exp_q[5] = 32'(stores * 64'(x_cols));
    exp_q[6] = slots;
    rnd1 = (op == 3'd6) ? 3'd1 : 3'd0;
    rnd2 = (op == 3'd2 || op == 3'd4 || op == 3'd7) ? 3'd1 : 3'd0;
    case (op)
      3'd0, 3'd1: fpu1 = 5'd0;
      3'd2, 3'd3: fpu1 = 5'd2;
      3'd4, 3'd5: fpu1 = 5'd3;
      default:    fpu1 = 5'd7;
    endcase
    exp_q[7] = {rnd1, rnd2, fpu1, 5'd7, fmt, fmt, 9'd0, op != 3'd0};
  endtask

  task automatic check_results(input word_t exp_status);
    word_t got;
    read_reg(ADDR_STATUS, got);
    check_word("status", got, exp_status);
    for (int i = 0; i < 8; i++) begin
      read_reg(reg_addr_t'(ADDR_X_ITERS + i), got);
      check_word(result_name(i), got, exp_q[i]);
    end
  endtask

  initial begin
    word_t got;
    int    extra;
    clk_int   = 1'b0;
    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    wr_en_i   = 1'b0;
    wr_addr_i = '0;
    wr_data_i = '0;
    rd_addr_i = '0;
    cycle_cnt = 0;
    err_cnt   = 0;
    row_errs  = 0;
    check_cnt = 0;
    test_cnt  = 0;
    seed      = 32'hd073_41b4;
    load_table();
    repeat (3) @(negedge clk_int);
    rst_ni = 1'b1;

    // Everything idle and zero out of reset
    assert (!busy_o) else begin
      $display("busy_o is high after reset");
      flag_error();
    end
    for (int i = 0; i < 8; i++) exp_q[i] = '0;
    check_results(32'd0);
    read_reg(reg_addr_t'(13), got);
    check_word("unmapped", got, 32'd0);
    finish_test("reset values");

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].rnd) begin
        rows[r].m = dim_t'($random(seed));
        rows[r].n = dim_t'($random(seed));
        rows[r].k = dim_t'($random(seed));
      end
      model_job(rows[r].m, rows[r].n, rows[r].k, rows[r].op, rows[r].fmt);
      if (!rows[r].rnd) exp_q[3] = rows[r].stores;
      write_config(rows[r].m, rows[r].n, rows[r].k, rows[r].op, rows[r].fmt);
      write_reg(ADDR_TRIGGER, 32'd1);
      wait_done();
      check_results(32'd2);
      finish_test($sformatf("row %0d m=%0d n=%0d k=%0d op=%0d fmt=%0d", r,
                            rows[r].m, rows[r].n, rows[r].k, rows[r].op, rows[r].fmt));
    end

    // Second trigger arrives while the first job is running
    model_job(16'd50, 16'd20, 16'd40, 3'd1, 3'd1);
    write_config(16'd50, 16'd20, 16'd40, 3'd1, 3'd1);
    write_reg(ADDR_TRIGGER, 32'd1);
    write_config(16'd7, 16'd9, 16'd3, 3'd6, 3'd2);
    assert (busy_o) else begin
      $display("busy_o dropped before the second trigger");
      flag_error();
    end
    write_reg(ADDR_TRIGGER, 32'd1);
    wait_done();
    extra = 0;
    repeat (QUIET_WAIT) begin
      @(negedge clk_int);
      if (done_o) extra++;
    end
    assert (extra == 0) else begin
      $display("done_o pulsed %0d more times after the dropped trigger", extra);
      flag_error();
    end
    check_results(32'd2);
    finish_test("trigger while busy");

    // Clear during the first multiply aborts the job
    write_config(16'd200, 16'd90, 16'd77, 3'd4, 3'd3);
    write_reg(ADDR_TRIGGER, 32'd1);
    repeat (10) @(negedge clk_int);
    clear_i = 1'b1;
    @(negedge clk_int);
    clear_i = 1'b0;
    assert (!busy_o) else begin
      $display("busy_o still high after clear");
      flag_error();
    end
    extra = 0;
    repeat (QUIET_WAIT) begin
      @(negedge clk_int);
      if (done_o) extra++;
    end
    assert (extra == 0) else begin
      $display("done_o pulsed after the job was cleared");
      flag_error();
    end
    for (int i = 0; i < 8; i++) exp_q[i] = '0;
    check_results(32'd0);
    model_job(16'd200, 16'd90, 16'd77, 3'd4, 3'd3);
    write_reg(ADDR_TRIGGER, 32'd1);
    wait_done();
    check_results(32'd2);
    finish_test("clear mid-run");

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
design/tiler_pkg.sv
design/seq_mult.sv
design/tiler_regfile.sv
design/gemm_tiler.sv
design/tiler_top.sv
sim/tb_tiler_top.sv

/* run.sh */
#!/bin/sh
# Build and run the tiler testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_tiler_top \
  --Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_tiler_top" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
  exit 0
fi
exit 1
